//--- vec_unit.f
rtl/vec_pkg.sv
rtl/vec_csr.sv
rtl/element_counter.sv
rtl/vec_regfile.sv
rtl/vec_lanes.sv
rtl/vec_issue.sv
rtl/vec_unit_top.sv
tb/tb_vec_unit.sv

//--- tb/tb_vec_unit.sv
// vector unit testbench
`timescale 1ns/10ps
`default_nettype none

module tb_vec_unit import vec_pkg::*; ();

  localparam int NUM_ROWS      = 17;
  localparam int TIMEOUT_LIMIT = NUM_ROWS * (VLMAX + 8) + 50;   // cycles spent waiting
  localparam int MODE_PLAIN    = 0;
  localparam int MODE_GHOST    = 1;   // second strobe while busy
  localparam int MODE_CLEAR    = 2;   // flush mid-run

  logic      CLK, nRST;
  logic      csr_we, instr_valid, stall, clear, ld_we, busy, done;
  csr_addr_t csr_addr;
  offset_t   csr_wdata, csr_rdata, ld_elem, pk_elem;
  vop_t      instr_op;
  vreg_t     instr_vd, instr_vs1, instr_vs2, ld_vreg, pk_vreg;
  elem_t     ld_data, pk_data;

  // stimulus table with one entry per instruction
  offset_t row_vl [NUM_ROWS];
  offset_t row_vstart [NUM_ROWS];
  vop_t    row_op [NUM_ROWS];
  vreg_t   row_vd [NUM_ROWS];
  vreg_t   row_vs1 [NUM_ROWS];
  vreg_t   row_vs2 [NUM_ROWS];
  logic    row_stall [NUM_ROWS];
  int      row_mode [NUM_ROWS];
  int      n_rows;

  elem_t       model [NUM_VREGS][VLMAX];   // expected register contents
  logic [31:0] lfsr_state;
  logic        waiting;                    // an instruction is in flight
  int          wait_cycles;

  vec_unit_top vec_unit_top_inst (
    .CLK, .nRST, .csr_we, .csr_addr, .csr_wdata, .csr_rdata,
    .instr_valid, .instr_op, .instr_vd, .instr_vs1, .instr_vs2,
    .stall, .clear, .ld_we, .ld_vreg, .ld_elem, .ld_data,
    .pk_vreg, .pk_elem, .pk_data, .busy, .done
  );

  always #50 CLK = ~CLK;   // 100 ns period

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [15:0] random_bits(input int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);   // one step per bit
      v = {v[14:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // sums and differences wrap at 16 bits
  function automatic elem_t expected_elem(input vop_t f, input elem_t a, input elem_t b);
    case (f)
      VOP_ADD: return elem_t'(a + b);
      VOP_SUB: return elem_t'(a - b);
      VOP_AND: return a & b;
      default: return a ^ b;
    endcase
  endfunction

  function automatic int clamp_vl(input offset_t v);
    return (int'(v) > VLMAX) ? VLMAX : int'(v);
  endfunction

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Testbench failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      stop_on_error($sformatf("mismatch at %0t: %s is %0h, expected %0h",
                              $time, name, got, expected));
    end
  endtask

  always @(negedge CLK) begin
    if (waiting) begin
      wait_cycles = wait_cycles + 1;
      if (wait_cycles > TIMEOUT_LIMIT) stop_on_error("timeout waiting for done");
    end
  end

  task automatic add_row(input int vl_v, input int vs_v, input vop_t op_v, input int vd_v,
                         input int a_v, input int b_v, input logic st_v, input int mode_v);
    row_vl[n_rows]     = offset_t'(vl_v);
    row_vstart[n_rows] = offset_t'(vs_v);
    row_op[n_rows]     = op_v;
    row_vd[n_rows]     = vreg_t'(vd_v);
    row_vs1[n_rows]    = vreg_t'(a_v);
    row_vs2[n_rows]    = vreg_t'(b_v);
    row_stall[n_rows]  = st_v;
    row_mode[n_rows]   = mode_v;
    n_rows++;
  endtask

  task automatic build_table();
    add_row(8, 0, VOP_ADD, 0, 1, 2, 1'b0, MODE_PLAIN);   // each opcode at full length
    add_row(8, 0, VOP_SUB, 3, 1, 2, 1'b0, MODE_PLAIN);
    add_row(8, 0, VOP_AND, 2, 0, 3, 1'b0, MODE_PLAIN);
    add_row(8, 0, VOP_XOR, 1, 3, 0, 1'b0, MODE_PLAIN);
    add_row(3, 0, VOP_ADD, 0, 1, 2, 1'b0, MODE_PLAIN);   // tail kept
    add_row(5, 0, VOP_SUB, 2, 3, 1, 1'b0, MODE_PLAIN);
    add_row(0, 0, VOP_XOR, 1, 2, 3, 1'b0, MODE_PLAIN);   // empty vector
    add_row(7, 3, VOP_ADD, 3, 0, 1, 1'b0, MODE_PLAIN);   // resume from vstart
    add_row(4, 6, VOP_SUB, 0, 1, 2, 1'b0, MODE_PLAIN);   // vstart past vl
    add_row(5, 5, VOP_AND, 2, 0, 1, 1'b0, MODE_PLAIN);
    add_row(8, 0, VOP_ADD, 1, 1, 2, 1'b0, MODE_PLAIN);   // vd aliases vs1
    add_row(6, 1, VOP_XOR, 2, 0, 2, 1'b0, MODE_PLAIN);   // vd aliases vs2
    add_row(8, 0, VOP_SUB, 3, 3, 3, 1'b1, MODE_PLAIN);   // random stalls
    add_row(8, 0, VOP_ADD, 0, 1, 2, 1'b1, MODE_GHOST);
    add_row(12, 2, VOP_AND, 1, 2, 3, 1'b1, MODE_PLAIN);  // vl saturates to 8
    add_row(8, 2, VOP_XOR, 2, 0, 1, 1'b0, MODE_CLEAR);
    add_row(5, 1, VOP_SUB, 0, 3, 2, 1'b1, MODE_PLAIN);   // still works after flush
  endtask

  // random contents through the load port
  task automatic fill_registers();
    elem_t v;
    for (int r = 0; r < NUM_VREGS; r++) begin
      for (int e = 0; e < VLMAX; e++) begin
        v = random_bits(ELEM_W);
        model[r][e] = v;
        @(posedge CLK);
        ld_we   <= 1'b1;
        ld_vreg <= vreg_t'(r);
        ld_elem <= offset_t'(e);
        ld_data <= v;
      end
    end
    @(posedge CLK);
    ld_we <= 1'b0;
  endtask

  task automatic expect_csr(input csr_addr_t addr, input int expected, input string name);
    @(posedge CLK);
    csr_addr <= addr;
    @(negedge CLK);
    check_value(name, csr_rdata, expected);
  endtask

  task automatic write_csrs(input int r);
    @(posedge CLK);
    csr_we    <= 1'b1;
    csr_addr  <= CSR_VL;
    csr_wdata <= row_vl[r];
    @(posedge CLK);
    csr_addr  <= CSR_VSTART;
    csr_wdata <= row_vstart[r];
    @(posedge CLK);
    csr_we <= 1'b0;
    expect_csr(CSR_VL, clamp_vl(row_vl[r]), "csr_rdata vl");
    expect_csr(CSR_VSTART, int'(row_vstart[r]), "csr_rdata vstart");
  endtask

  task automatic issue_strobe(input int r);
    @(posedge CLK);
    instr_valid <= 1'b1;
    instr_op    <= row_op[r];
    instr_vd    <= row_vd[r];
    instr_vs1   <= row_vs1[r];
    instr_vs2   <= row_vs2[r];
    @(posedge CLK);   // accepted here and busy from now on
  endtask

  task automatic run_instruction(input int r);
    logic got_done;
    got_done = 1'b0;
    issue_strobe(r);
    if (row_mode[r] == MODE_GHOST) begin
      instr_valid <= 1'b1;          // must be dropped while busy is high
      instr_op    <= VOP_XOR;
      instr_vd    <= row_vd[r] + 1'b1;
    end else begin
      instr_valid <= 1'b0;
    end
    waiting = 1'b1;
    while (!got_done) begin
      @(negedge CLK);
      if (done) begin
        got_done = 1'b1;
        check_value("busy at done", busy, 0);   // falls together with done
      end else begin
        check_value("busy", busy, 1);
      end
      @(posedge CLK);
      instr_valid <= 1'b0;
      stall <= (row_stall[r] && random_bits(1) != '0);
    end
    waiting = 1'b0;
    stall <= 1'b0;
  endtask

  task automatic run_with_clear(input int r);
    issue_strobe(r);
    instr_valid <= 1'b0;
    @(negedge CLK);
    check_value("busy", busy, 1);
    @(posedge CLK);
    clear <= 1'b1;   // first beat already issued
    @(posedge CLK);
    clear <= 1'b0;
    repeat (4) begin
      @(negedge CLK);
      check_value("busy after clear", busy, 0);
      check_value("done after clear", done, 0);   // flush never completes
    end
    expect_csr(CSR_VSTART, int'(row_vstart[r]), "vstart after clear");
    expect_csr(CSR_VL, clamp_vl(row_vl[r]), "vl after clear");
    // only the beat already in the lanes lands, the flushed beat must not
    update_model(r, int'(row_vstart[r]) + NUM_LANES);
    compare_registers();
  endtask

  // vd elements from vstart below stop, prefix and tail keep their values
  task automatic update_model(input int r, input int stop);
    for (int e = int'(row_vstart[r]); e < stop; e++) begin
      model[row_vd[r]][e] = expected_elem(row_op[r], model[row_vs1[r]][e],
                                          model[row_vs2[r]][e]);
    end
  endtask

  task automatic compare_registers();
    for (int r = 0; r < NUM_VREGS; r++) begin
      for (int e = 0; e < VLMAX; e++) begin
        @(posedge CLK);
        pk_vreg <= vreg_t'(r);
        pk_elem <= offset_t'(e);
        @(negedge CLK);
        check_value($sformatf("pk_data v%0d[%0d]", r, e), pk_data, model[r][e]);
      end
    end
  endtask

  initial begin
    CLK         = 1'b0;
    nRST        = 1'b0;
    csr_we      = 1'b0;
    csr_addr    = CSR_VL;
    csr_wdata   = '0;
    instr_valid = 1'b0;
    instr_op    = VOP_ADD;
    instr_vd    = '0;
    instr_vs1   = '0;
    instr_vs2   = '0;
    stall       = 1'b0;
    clear       = 1'b0;
    ld_we       = 1'b0;
    ld_vreg     = '0;
    ld_elem     = '0;
    ld_data     = '0;
    pk_vreg     = '0;
    pk_elem     = '0;
    lfsr_state  = 32'h18f3ab24;
    waiting     = 1'b0;
    wait_cycles = 0;
    n_rows      = 0;
    build_table();
    repeat (2) @(posedge CLK);
    nRST <= 1'b1;
    for (int r = 0; r < n_rows; r++) begin
      fill_registers();
      write_csrs(r);
      if (row_mode[r] == MODE_CLEAR) begin
        run_with_clear(r);
      end else begin
        run_instruction(r);
        update_model(r, clamp_vl(row_vl[r]));
        compare_registers();
        expect_csr(CSR_VSTART, 0, "vstart after done");   // cleared on completion
      end
    end
    @(posedge CLK);
    $display("Testbench passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- rtl/vec_unit_top.sv
// vector execution unit top
`timescale 1ns/10ps
`default_nettype none

module vec_unit_top import vec_pkg::*; (
  input  logic      CLK,
  input  logic      nRST,
  // csr access
  input  logic      csr_we,
  input  csr_addr_t csr_addr,
  input  offset_t   csr_wdata,
  output offset_t   csr_rdata,
  // instruction issue
  input  logic      instr_valid,
  input  vop_t      instr_op,
  input  vreg_t     instr_vd,
  input  vreg_t     instr_vs1,
  input  vreg_t     instr_vs2,
  input  logic      stall,
  input  logic      clear,
  // register setup and inspection
  input  logic      ld_we,
  input  vreg_t     ld_vreg,
  input  offset_t   ld_elem,
  input  elem_t     ld_data,
  input  vreg_t     pk_vreg,
  input  offset_t   pk_elem,
  output elem_t     pk_data,
  output logic      busy,
  output logic      done
);

  offset_t vl, vstart, offset, wr_offset;
  logic    start, run, beat, last;
  vop_t    op;
  vreg_t   vd, vs1, vs2;
  elem_t   a0, a1, b0, b1;   // a from vs1, b from vs2
  logic    wr_en0, wr_en1;
  elem_t   wr_data0, wr_data1;

  vec_csr vec_csr_inst (
    .CLK, .nRST, .csr_we, .csr_addr, .csr_wdata,
    .vstart_clear (done),   // completion resets vstart
    .csr_rdata, .vl, .vstart
  );

  element_counter element_counter_inst (
    .CLK, .nRST, .vl, .vstart, .start, .run, .stall, .clear,
    .offset, .beat, .last
  );

  vec_issue vec_issue_inst (
    .CLK, .nRST, .instr_valid, .instr_op, .instr_vd, .instr_vs1, .instr_vs2,
    .beat, .last, .stall, .clear,
    .op, .vd, .vs1, .vs2, .start, .run, .busy, .done
  );

  vec_regfile vec_regfile_inst (
    .CLK, .nRST,
    .rd_vreg_a (vs1), .rd_vreg_b (vs2), .rd_offset (offset),
    .rd_data_a0 (a0), .rd_data_a1 (a1), .rd_data_b0 (b0), .rd_data_b1 (b1),
    .wr_vreg (vd),   // latched vd, stable until done
    .wr_offset, .wr_en0, .wr_en1, .wr_data0, .wr_data1,
    .ld_we, .ld_vreg, .ld_elem, .ld_data,
    .pk_vreg, .pk_elem, .pk_data
  );

  vec_lanes vec_lanes_inst (
    .CLK, .nRST, .op, .beat, .clear, .offset, .vl,
    .a0, .a1, .b0, .b1,
    .wr_offset, .wr_en0, .wr_en1, .wr_data0, .wr_data1
  );

endmodule

`default_nettype wire

//--- rtl/vec_issue.sv
// instruction latch and issue control
`timescale 1ns/10ps
`default_nettype none

module vec_issue import vec_pkg::*; (
  input  logic  CLK,
  input  logic  nRST,
  input  logic  instr_valid,
  input  vop_t  instr_op,
  input  vreg_t instr_vd,
  input  vreg_t instr_vs1,
  input  vreg_t instr_vs2,
  input  logic  beat,
  input  logic  last,
  input  logic  stall,   // tells an empty body apart from a held beat
  input  logic  clear,
  output vop_t  op,
  output vreg_t vd,
  output vreg_t vs1,
  output vreg_t vs2,
  output logic  start,
  output logic  run,
  output logic  busy,
  output logic  done
);

  issue_state_t state, next_state;

  assign busy  = (state != IDLE);
  assign run   = (state == RUN);
  assign start = instr_valid & (state == IDLE) & ~clear;   // strobe dropped when busy

  always_comb begin
    next_state = state;
    case (state)
      IDLE: begin
        if (start) next_state = RUN;
      end
      RUN: begin
        if (last) begin
          next_state = DRAIN;   // final beat now in the lanes
        end else if (~stall && ~beat) begin
          next_state = DRAIN;   // vstart >= vl, nothing to issue
        end
      end
      DRAIN: begin
        next_state = IDLE;      // last lane write happens here
      end
      default: next_state = IDLE;
    endcase
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (~nRST) begin
      state <= IDLE;
      done  <= 1'b0;
    end else if (clear) begin
      state <= IDLE;
      done  <= 1'b0;   // flush never completes
    end else begin
      state <= next_state;
      done  <= (state == DRAIN);
    end
  end

  // fields held until the next accepted strobe
  always_ff @(posedge CLK) begin
    if (start) begin
      op  <= instr_op;
      vd  <= instr_vd;
      vs1 <= instr_vs1;
      vs2 <= instr_vs2;
    end
  end

endmodule

`default_nettype wire

//--- rtl/vec_lanes.sv
// parallel element ALUs
`timescale 1ns/10ps
`default_nettype none

module vec_lanes import vec_pkg::*; (
  input  logic    CLK,
  input  logic    nRST,
  input  vop_t    op,
  input  logic    beat,
  input  logic    clear,
  input  offset_t offset,   // element index of lane 0
  input  offset_t vl,
  input  elem_t   a0,
  input  elem_t   a1,
  input  elem_t   b0,
  input  elem_t   b1,
  output offset_t wr_offset,
  output logic    wr_en0,
  output logic    wr_en1,
  output elem_t   wr_data0,
  output elem_t   wr_data1
);

  logic [OFFSET_W:0] idx0, idx1;
  logic              body0, body1;   // element below vl

  // one lane's operation, sums and differences wrap
  function automatic elem_t lane_alu(input vop_t f, input elem_t a, input elem_t b);
    elem_t r;
    case (f)
      VOP_ADD: r = a + b;
      VOP_SUB: r = a - b;
      VOP_AND: r = a & b;
      default: r = a ^ b;
    endcase
    return r;
  endfunction

  assign idx0  = {1'b0, offset};
  assign idx1  = {1'b0, offset} + 1'b1;
  assign body0 = idx0 < {1'b0, vl};
  assign body1 = idx1 < {1'b0, vl};   // tail elements stay untouched

  // control, cleared on flush
  always_ff @(posedge CLK, negedge nRST) begin
    if (~nRST) begin
      wr_en0 <= 1'b0;
      wr_en1 <= 1'b0;
    end else if (clear) begin
      wr_en0 <= 1'b0;
      wr_en1 <= 1'b0;
    end else begin
      wr_en0 <= beat & body0;
      wr_en1 <= beat & body1;
    end
  end

  // payload, only meaningful with its enable
  always_ff @(posedge CLK) begin
    wr_offset <= offset;
    wr_data0  <= lane_alu(op, a0, b0);
    wr_data1  <= lane_alu(op, a1, b1);
  end

endmodule

`default_nettype wire

//--- rtl/vec_regfile.sv
// vector register file
`timescale 1ns/10ps
`default_nettype none

module vec_regfile import vec_pkg::*; (
  input  logic    CLK,
  input  logic    nRST,
  // lane read ports
  input  vreg_t   rd_vreg_a,
  input  vreg_t   rd_vreg_b,
  input  offset_t rd_offset,
  output elem_t   rd_data_a0,
  output elem_t   rd_data_a1,
  output elem_t   rd_data_b0,
  output elem_t   rd_data_b1,
  // lane write port
  input  vreg_t   wr_vreg,
  input  offset_t wr_offset,
  input  logic    wr_en0,
  input  logic    wr_en1,
  input  elem_t   wr_data0,
  input  elem_t   wr_data1,
  // scalar load and peek
  input  logic    ld_we,
  input  vreg_t   ld_vreg,
  input  offset_t ld_elem,
  input  elem_t   ld_data,
  input  vreg_t   pk_vreg,
  input  offset_t pk_elem,
  output elem_t   pk_data
);

  elem_t mem [NUM_VREGS][VLMAX];

  logic [OFFSET_W:0] rd_idx0, rd_idx1;   // widened so offset+1 can't wrap
  logic [OFFSET_W:0] wr_idx0, wr_idx1;

  assign rd_idx0 = {1'b0, rd_offset};
  assign rd_idx1 = {1'b0, rd_offset} + 1'b1;
  assign wr_idx0 = {1'b0, wr_offset};
  assign wr_idx1 = {1'b0, wr_offset} + 1'b1;

  // out of range reads give zero
  always_comb begin
    rd_data_a0 = '0;
    rd_data_b0 = '0;
    rd_data_a1 = '0;
    rd_data_b1 = '0;
    pk_data    = '0;
    if (rd_idx0 < VLMAX) begin
      rd_data_a0 = mem[rd_vreg_a][rd_idx0[IDX_W-1:0]];
      rd_data_b0 = mem[rd_vreg_b][rd_idx0[IDX_W-1:0]];
    end
    if (rd_idx1 < VLMAX) begin
      rd_data_a1 = mem[rd_vreg_a][rd_idx1[IDX_W-1:0]];
      rd_data_b1 = mem[rd_vreg_b][rd_idx1[IDX_W-1:0]];
    end
    if (pk_elem < VLMAX) pk_data = mem[pk_vreg][pk_elem[IDX_W-1:0]];   // peek
  end

  // load first so lane writes override it
  always_ff @(posedge CLK, negedge nRST) begin
    if (~nRST) begin
      for (int r = 0; r < NUM_VREGS; r++) begin
        for (int e = 0; e < VLMAX; e++) begin
          mem[r][e] <= '0;
        end
      end
    end else begin
      if (ld_we && ld_elem < VLMAX) mem[ld_vreg][ld_elem[IDX_W-1:0]] <= ld_data;
      if (wr_en0 && wr_idx0 < VLMAX) mem[wr_vreg][wr_idx0[IDX_W-1:0]] <= wr_data0;
      if (wr_en1 && wr_idx1 < VLMAX) mem[wr_vreg][wr_idx1[IDX_W-1:0]] <= wr_data1;
    end
  end

endmodule

`default_nettype wire

//--- rtl/element_counter.sv
// element offset counter
`timescale 1ns/10ps
`default_nettype none

module element_counter import vec_pkg::*; (
  input  logic    CLK,
  input  logic    nRST,
  input  offset_t vl,
  input  offset_t vstart,
  input  logic    start,   // instruction accepted
  input  logic    run,     // issue fsm in RUN
  input  logic    stall,
  input  logic    clear,
  output offset_t offset,
  output logic    beat,    // element group issues this cycle
  output logic    last     // this beat reaches vl
);

  logic [OFFSET_W:0] off_sum;   // one extra bit, vstart can sit near the top

  assign off_sum = {1'b0, offset} + (OFFSET_W+1)'(NUM_LANES);

  // issue only while inside the active body
  assign beat = run & ~stall & (offset < vl);
  assign last = beat & (off_sum >= {1'b0, vl});

  // next offset selection
  // clear > start > finishing beat > normal step
  always_ff @(posedge CLK, negedge nRST) begin
    if (~nRST) begin
      offset <= '0;
    end else if (clear) begin
      offset <= '0;
    end else if (start) begin
      offset <= vstart;   // resume point, zero unless software set it
    end else if (last) begin
      offset <= '0;       // done with this vector
    end else if (beat) begin
      offset <= off_sum[OFFSET_W-1:0];
    end
  end

  // stall or an empty body just holds the offset

endmodule

`default_nettype wire

//--- rtl/vec_csr.sv
// vl and vstart configuration
`timescale 1ns/10ps
`default_nettype none

module vec_csr import vec_pkg::*; (
  input  logic      CLK,
  input  logic      nRST,
  input  logic      csr_we,
  input  csr_addr_t csr_addr,
  input  offset_t   csr_wdata,
  input  logic      vstart_clear,   // instruction finished
  output offset_t   csr_rdata,
  output offset_t   vl,
  output offset_t   vstart
);

  offset_t vl_sat;   // clamped write value

  // vl can never exceed one register's worth of elements
  always_comb begin
    vl_sat = csr_wdata;
    if (csr_wdata > offset_t'(VLMAX)) begin
      vl_sat = offset_t'(VLMAX);
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (~nRST) begin
      vl <= '0;
    end else if (csr_we && csr_addr == CSR_VL) begin
      vl <= vl_sat;
    end
  end

  // software write wins over the completion clear
  always_ff @(posedge CLK, negedge nRST) begin
    if (~nRST) begin
      vstart <= '0;
    end else if (csr_we && csr_addr == CSR_VSTART) begin
      vstart <= csr_wdata;
    end else if (vstart_clear) begin
      vstart <= '0;   // next instruction starts at element 0
    end
  end

  // readback is combinational
  always_comb begin
    case (csr_addr)
      CSR_VL:  csr_rdata = vl;
      default: csr_rdata = vstart;
    endcase
  end

endmodule

`default_nettype wire

//--- rtl/vec_pkg.sv
// vector unit shared definitions
`default_nettype none

package vec_pkg;

  localparam int NUM_LANES = 2;   // elements per beat
  localparam int VLMAX     = 8;   // elements per vector register
  localparam int NUM_VREGS = 4;
  localparam int ELEM_W    = 16;
  localparam int OFFSET_W  = 4;   // holds 0..VLMAX inclusive
  localparam int IDX_W     = $clog2(VLMAX);   // element select inside a register
  localparam int VREG_W    = $clog2(NUM_VREGS);

  typedef logic [ELEM_W-1:0]   elem_t;
  typedef logic [OFFSET_W-1:0] offset_t;
  typedef logic [VREG_W-1:0]   vreg_t;
  typedef logic [0:0]          csr_addr_t;

  localparam csr_addr_t CSR_VL     = 1'b0;
  localparam csr_addr_t CSR_VSTART = 1'b1;

  typedef enum logic [1:0] {
    VOP_ADD = 2'd0,
    VOP_SUB = 2'd1,   // vs1 - vs2
    VOP_AND = 2'd2,
    VOP_XOR = 2'd3
  } vop_t;

  typedef enum logic [1:0] {IDLE, RUN, DRAIN} issue_state_t;

endpackage

`default_nettype wire
